// ==== sim.f ====
+incdir+logic
logic/knight_pkg.sv
logic/cmd_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_cmd_link.sv
logic/cmd_proc.sv
logic/knight_ctrl.sv
dv/knight_ctrl_tb.sv

// ==== dv/cmd_input.txt ====
# cmd(hex) heading(hex, checked on moves only) crossings(dec) fanfare(hex) ack(hex)
# Opcode 2 calibrates, 4 moves, 5 moves with fanfare, anything else is only acknowledged
2000 000 0 0 a5
4002 000 2 0 a5
43f3 3ff 3 0 a5
57f1 7ff 1 1 a5
4bf0 bff 0 0 a5
5001 000 1 1 a5
7000 000 0 0 a5
2000 000 0 0 a5
5bf2 bff 2 1 a5
53f0 3ff 0 1 a5
4004 000 4 0 a5

// ==== dv/knight_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "knight_cfg.svh"

module knight_ctrl_tb;

  localparam int WAIT_LIMIT = 4000;

  logic        clk;
  logic        rst_n;
  logic        rx;
  logic        tx;
  logic        cal_done;
  logic        strt_cal;
  logic        heading_rdy;
  logic [11:0] desired_heading;
  logic        moving;
  logic        cntr_ir;
  logic        fanfare;

  logic [31:0] lcg_state;
  logic        moving_q;
  int          cal_pulses;
  int          move_starts;
  int          fanfare_pulses;

  knight_ctrl knight_ctrl_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .rx              (rx),
    .tx              (tx),
    .cal_done        (cal_done),
    .strt_cal        (strt_cal),
    .heading_rdy     (heading_rdy),
    .desired_heading (desired_heading),
    .moving          (moving),
    .cntr_ir         (cntr_ir),
    .fanfare         (fanfare)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Strobes are counted on the falling edge where they are stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (strt_cal) cal_pulses++;
      if (fanfare) fanfare_pulses++;
      if (moving && !moving_q) move_starts++;
    end
    moving_q = moving;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Sensor gaps of 2 to 17 cycles, ending 1 ns after a rising edge
  task automatic random_gap();
    lcg_state = lcg_next(lcg_state);
    repeat (2 + lcg_state[19:16]) @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timed out while waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped after a timeout");
  endtask

  // Selector 1 picks moving and anything else picks tx
  function automatic logic probe(input int sel);
    return (sel == 1) ? moving : tx;
  endfunction

  // Returns on the falling edge where the selected output has the level
  task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (probe(sel) !== level) begin
      if (cycles == WAIT_LIMIT) timed_out(what);
      cycles++;
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Serial driver and monitor
  ////////////////////////////////////////////////////////////

  // Start bit, eight data bits LSB first, then the stop bit
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (`KNIGHT_BAUD_DIV) @(posedge clk);
      #1;
    end
  endtask

  // Half a bit after the start edge lands mid-bit for every later sample
  task automatic receive_byte(output logic [7:0] data);
    wait_level(2, 1'b0, "a start bit on tx");
    repeat (`KNIGHT_BAUD_DIV / 2) @(negedge clk);
    check_value("tx start bit", tx, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (`KNIGHT_BAUD_DIV) @(negedge clk);
      data[i] = tx;
    end
    repeat (`KNIGHT_BAUD_DIV) @(negedge clk);
    check_value("tx stop bit", tx, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Sensor model
  ////////////////////////////////////////////////////////////
  task automatic drive_sensors(input logic [3:0] op, input int n_cross,
                               input logic [11:0] exp_head);
    if (op == 4'h2) begin
      random_gap();
      cal_done = 1'b1;
      @(posedge clk);
      #1;
      cal_done = 1'b0;
    end else if (op == 4'h4 || op == 4'h5) begin
      random_gap();
      check_value("desired_heading", desired_heading, exp_head);
      heading_rdy = 1'b1;
      // With no squares to go the robot never moves
      if (n_cross > 0) wait_level(1, 1'b1, "moving to rise");
      else repeat (2) @(negedge clk);
      @(posedge clk);
      #1;
      heading_rdy = 1'b0;
      for (int i = 0; i < n_cross; i++) begin
        random_gap();
        check_value("moving", moving, 1'b1);
        cntr_ir = 1'b1;
        @(posedge clk);
        #1;
        cntr_ir = 1'b0;
      end
      if (n_cross > 0) wait_level(1, 1'b0, "moving to fall after the last crossing");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int                fd;
    int                n_cross;
    int                n_cmds;
    int                cal_base;
    int                move_base;
    int                ff_base;
    logic [15:0]       cmd;
    logic [11:0]       exp_head;
    logic [3:0]        exp_ff;
    logic [7:0]        exp_resp;
    logic [7:0]        got_resp;
    logic [3:0]        op;
    logic [8*128-1:0]  header;
    rst_n       = 1'b0;
    rx          = 1'b1;
    cal_done    = 1'b0;
    heading_rdy = 1'b0;
    cntr_ir     = 1'b0;
    moving_q    = 1'b0;
    lcg_state   = 32'h6b97;
    n_cmds      = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Outputs must come out of reset idle
    check_value("tx", tx, 1'b1);
    check_value("strt_cal", strt_cal, 1'b0);
    check_value("moving", moving, 1'b0);
    check_value("fanfare", fanfare, 1'b0);
    check_value("desired_heading", desired_heading, 12'h000);

    fd = $fopen("dv/cmd_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/cmd_input.txt");
      $display("=== FAIL ===");
      $fatal(1, "Missing stimulus");
    end
    void'($fgets(header, fd));
    void'($fgets(header, fd));

    while ($fscanf(fd, "%h %h %d %h %h\n", cmd, exp_head, n_cross, exp_ff, exp_resp) == 5) begin
      op        = cmd[15:12];
      cal_base  = cal_pulses;
      move_base = move_starts;
      ff_base   = fanfare_pulses;
      // High byte goes out first
      send_byte(cmd[15:8]);
      send_byte(cmd[7:0]);
      fork
        receive_byte(got_resp);
        drive_sensors(op, n_cross, exp_head);
      join
      @(posedge clk);
      #1;
      check_value("ack byte", got_resp, exp_resp);
      check_value("strt_cal pulse count", cal_pulses - cal_base, op == 4'h2);
      check_value("moving start count", move_starts - move_base,
                  (op == 4'h4 || op == 4'h5) && n_cross != 0);
      check_value("fanfare pulse count", fanfare_pulses - ff_base, exp_ff);
      check_value("moving", moving, 1'b0);
      n_cmds++;
    end
    $fclose(fd);

    if (n_cmds == 0) begin
      $display("No commands were read from the stimulus file");
      $display("=== FAIL ===");
      $fatal(1, "Empty stimulus");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== logic/knight_ctrl.sv ====
`timescale 1ns/1ps

module knight_ctrl (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  output logic        tx,
  input  logic        cal_done,
  output logic        strt_cal,
  input  logic        heading_rdy,
  output logic [11:0] desired_heading,
  output logic        moving,
  input  logic        cntr_ir,
  output logic        fanfare
);

  ////////////////////////////////////////////////////////////
  // Command link between serial front end and decoder
  ////////////////////////////////////////////////////////////
  cmd_if cmd_bus ();

  // Serial side handles byte framing and the ack byte
  uart_cmd_link link_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .tx    (tx),
    .link  (cmd_bus.link)
  );

  ////////////////////////////////////////////////////////////
  // Command decoding and robot control outputs
  ////////////////////////////////////////////////////////////
  cmd_proc proc_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .proc            (cmd_bus.proc),
    .cal_done        (cal_done),
    .strt_cal        (strt_cal),
    .heading_rdy     (heading_rdy),
    .desired_heading (desired_heading),
    .moving          (moving),
    .cntr_ir         (cntr_ir),
    .fanfare         (fanfare)
  );

endmodule

// ==== logic/cmd_proc.sv ====
`timescale 1ns/1ps
`include "knight_cfg.svh"

module cmd_proc (
  input  logic        clk,
  input  logic        rst_n,
  cmd_if.proc         proc,
  input  logic        cal_done,
  output logic        strt_cal,
  input  logic        heading_rdy,
  output logic [11:0] desired_heading,
  output logic        moving,
  input  logic        cntr_ir,
  output logic        fanfare
);
  import knight_pkg::*;

  cmd_state_e                     state;
  knight_opcode_e                 opcode;
  logic [7:0]                     head_code;
  logic [3:0]                     sq_cnt;
  logic                           fanfare_req;
  logic [`KNIGHT_SYNC_STAGES-1:0] ir_sync;
  logic                           ir_prev;
  logic                           ir_rise;
  logic                           accept;

  ////////////////////////////////////////////////////////////
  // Command fields
  ////////////////////////////////////////////////////////////
  assign opcode    = knight_opcode_e'(proc.cmd[15:12]);
  assign head_code = proc.cmd[11:4];

  // A pending command is taken only from IDLE
  assign accept           = (state == CMD_IDLE) && proc.cmd_rdy;
  assign proc.clr_cmd_rdy = accept;
  assign proc.resp        = `KNIGHT_ACK;

  ////////////////////////////////////////////////////////////
  // Center IR line detection
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ir_sync <= '0;
      ir_prev <= 1'b0;
    end else begin
      ir_sync <= {ir_sync[`KNIGHT_SYNC_STAGES-2:0], cntr_ir};
      ir_prev <= ir_sync[`KNIGHT_SYNC_STAGES-1];
    end
  end

  // One cycle per line crossing
  assign ir_rise = ir_sync[`KNIGHT_SYNC_STAGES-1] & ~ir_prev;

  // Square count and fanfare request are latched with the command
  always_ff @(posedge clk) begin
    if (accept) begin
      sq_cnt      <= proc.cmd[3:0];
      fanfare_req <= (opcode == OP_MOVE_FANFARE);
    end else if (state == CMD_MOVE && ir_rise) begin
      sq_cnt <= sq_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state           <= CMD_IDLE;
      strt_cal        <= 1'b0;
      moving          <= 1'b0;
      fanfare         <= 1'b0;
      desired_heading <= '0;
      proc.send_resp  <= 1'b0;
    end else begin
      // Strobes default low and last a single cycle
      strt_cal       <= 1'b0;
      fanfare        <= 1'b0;
      proc.send_resp <= 1'b0;
      case (state)
        CMD_IDLE: if (accept) begin
          case (opcode)
            OP_CAL: begin
              strt_cal <= 1'b1;
              state    <= CMD_CAL_WAIT;
            end
            OP_MOVE, OP_MOVE_FANFARE: begin
              // Heading code zero is north and is not padded
              desired_heading <= (head_code == 8'h00) ? 12'h000 : {head_code, 4'hF};
              state           <= CMD_HEAD_WAIT;
            end
            // Unknown opcode is acknowledged and otherwise ignored
            default: begin
              proc.send_resp <= 1'b1;
              state          <= CMD_RESPOND;
            end
          endcase
        end
        CMD_CAL_WAIT: if (cal_done) begin
          proc.send_resp <= 1'b1;
          state          <= CMD_RESPOND;
        end
        CMD_HEAD_WAIT: if (heading_rdy) begin
          if (sq_cnt == 4'd0) begin
            proc.send_resp <= 1'b1;
            fanfare        <= fanfare_req;
            state          <= CMD_RESPOND;
          end else begin
            moving <= 1'b1;
            state  <= CMD_MOVE;
          end
        end
        // Last crossing ends the move and triggers the acknowledge
        CMD_MOVE: if (ir_rise && sq_cnt == 4'd1) begin
          moving         <= 1'b0;
          proc.send_resp <= 1'b1;
          fanfare        <= fanfare_req;
          state          <= CMD_RESPOND;
        end
        // Hold off new commands until the ack byte is out
        CMD_RESPOND: if (proc.resp_sent) state <= CMD_IDLE;
        default: state <= CMD_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/uart_cmd_link.sv ====
`timescale 1ns/1ps

module uart_cmd_link (
  input  logic clk,
  input  logic rst_n,
  input  logic rx,
  output logic tx,
  cmd_if.link  link
);

  logic [7:0] rx_data;
  logic       rx_rdy;
  logic       byte_sel;
  logic       tx_busy;
  logic       trmt;
  logic       tx_done;

  ////////////////////////////////////////////////////////////
  // Serial receiver and command assembly
  ////////////////////////////////////////////////////////////
  uart_rx rx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_data (rx_data),
    .rdy     (rx_rdy)
  );

  // High when the next byte completes the command
  always_ff @(posedge clk) begin
    if (!rst_n)      byte_sel <= 1'b0;
    else if (rx_rdy) byte_sel <= ~byte_sel;
  end

  // First byte is the high half of the command
  always_ff @(posedge clk) begin
    if (rx_rdy && !byte_sel) link.cmd[15:8] <= rx_data;
    if (rx_rdy && byte_sel)  link.cmd[7:0]  <= rx_data;
  end

  // A fresh first byte also withdraws any command still pending
  always_ff @(posedge clk) begin
    if (!rst_n)                    link.cmd_rdy <= 1'b0;
    else if (rx_rdy && byte_sel)   link.cmd_rdy <= 1'b1;
    else if (rx_rdy)               link.cmd_rdy <= 1'b0;
    else if (link.clr_cmd_rdy)     link.cmd_rdy <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  // Requests that arrive mid-frame are dropped
  assign trmt = link.send_resp & ~tx_busy;

  always_ff @(posedge clk) begin
    if (!rst_n)       tx_busy <= 1'b0;
    else if (trmt)    tx_busy <= 1'b1;
    else if (tx_done) tx_busy <= 1'b0;
  end

  uart_tx tx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (link.resp),
    .tx      (tx),
    .tx_done (tx_done)
  );

  assign link.resp_sent = tx_done;

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`include "knight_cfg.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       trmt,
  input  logic [7:0] tx_data,
  output logic       tx,
  output logic       tx_done
);
  import knight_pkg::*;

  localparam int BAUD_W = $clog2(`KNIGHT_BAUD_DIV);

  uart_state_e       state;
  logic [9:0]        shift_reg;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic              bit_end;

  assign bit_end = (baud_cnt == BAUD_W'(`KNIGHT_BAUD_DIV - 1));

  // Line level is always the bottom of the shift register
  assign tx = shift_reg[0];

  ////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= UART_IDLE;
      shift_reg <= '1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      tx_done   <= 1'b0;
    end else begin
      tx_done  <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      // Ones fill in from the top so the line returns to idle high
      if (state != UART_IDLE && bit_end) shift_reg <= {1'b1, shift_reg[9:1]};
      case (state)
        UART_IDLE: begin
          baud_cnt <= '0;
          if (trmt) begin
            shift_reg <= {1'b1, tx_data, 1'b0};
            state     <= UART_START;
          end
        end
        UART_START: if (bit_end) begin
          bit_cnt <= '0;
          state   <= UART_DATA;
        end
        UART_DATA: if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state <= UART_STOP;
        end
        // Done only after the full stop bit has been on the line
        UART_STOP: if (bit_end) begin
          tx_done <= 1'b1;
          state   <= UART_IDLE;
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`include "knight_cfg.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_data,
  output logic       rdy
);
  import knight_pkg::*;

  localparam int BAUD_W = $clog2(`KNIGHT_BAUD_DIV);

  uart_state_e                    state;
  logic [`KNIGHT_SYNC_STAGES-1:0] rx_sync;
  logic                           rx_s;
  logic [BAUD_W-1:0]              baud_cnt;
  logic [2:0]                     bit_cnt;
  logic                           half_bit;
  logic                           full_bit;

  // Line idles high, so the chain resets to ones to avoid a false start
  always_ff @(posedge clk) begin
    if (!rst_n) rx_sync <= '1;
    else        rx_sync <= {rx_sync[`KNIGHT_SYNC_STAGES-2:0], rx};
  end

  assign rx_s     = rx_sync[`KNIGHT_SYNC_STAGES-1];
  assign half_bit = (baud_cnt == BAUD_W'(`KNIGHT_BAUD_DIV / 2 - 1));
  assign full_bit = (baud_cnt == BAUD_W'(`KNIGHT_BAUD_DIV - 1));

  ////////////////////////////////////////////////////////////
  // Bit timing and framing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= UART_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rdy      <= 1'b0;
    end else begin
      rdy      <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          baud_cnt <= '0;
          if (!rx_s) state <= UART_START;
        end
        // Wait half a bit and confirm the start bit is still low
        UART_START: if (half_bit) begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          state    <= rx_s ? UART_IDLE : UART_DATA;
        end
        // Each sample now lands in the middle of a data bit
        UART_DATA: if (full_bit) begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state <= UART_STOP;
        end
        UART_STOP: if (full_bit) begin
          rdy   <= 1'b1;
          state <= UART_IDLE;
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // Data arrives LSB first so shift in from the top
  always_ff @(posedge clk) begin
    if (state == UART_DATA && full_bit) rx_data <= {rx_s, rx_data[7:1]};
  end

endmodule

// ==== logic/cmd_if.sv ====
`timescale 1ns/1ps

// Command link between the serial front end and the command processor
interface cmd_if;

  // Assembled 16-bit command and its ready flag from the link
  logic [15:0] cmd;
  logic        cmd_rdy;

  // Processor side: clears cmd_rdy and requests a response byte
  logic        clr_cmd_rdy;
  logic        send_resp;
  logic [7:0]  resp;

  // Pulses once the response byte has left the transmitter
  logic        resp_sent;

  modport link (
    output cmd, cmd_rdy, resp_sent,
    input  clr_cmd_rdy, send_resp, resp
  );

  modport proc (
    input  cmd, cmd_rdy, resp_sent,
    output clr_cmd_rdy, send_resp, resp
  );

endinterface

// ==== logic/knight_pkg.sv ====
package knight_pkg;

  ////////////////////////////////////////////////////////////
  // Command opcodes
  ////////////////////////////////////////////////////////////

  // Upper nibble of every 16-bit command from the remote station
  // Codes outside this set are ignored but still acknowledged
  typedef enum logic [3:0] {
    OP_CAL          = 4'h2,
    OP_MOVE         = 4'h4,
    OP_MOVE_FANFARE = 4'h5
  } knight_opcode_e;

  ////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////

  // Shared by the serial receiver and the serial transmitter
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // Command processor states
  typedef enum logic [2:0] {
    CMD_IDLE,
    CMD_CAL_WAIT,
    CMD_HEAD_WAIT,
    CMD_MOVE,
    CMD_RESPOND
  } cmd_state_e;

endpackage

// ==== logic/knight_cfg.svh ====
`ifndef KNIGHT_CFG_SVH
`define KNIGHT_CFG_SVH

////////////////////////////////////////////////////////////
// Serial link settings
////////////////////////////////////////////////////////////

// Number of clk cycles that make up one bit on rx and tx
`define KNIGHT_BAUD_DIV 16

// Byte sent back to the remote station when a command completes
`define KNIGHT_ACK 8'hA5

////////////////////////////////////////////////////////////
// Input conditioning
////////////////////////////////////////////////////////////

// Flops in each synchronizer chain for asynchronous inputs
`define KNIGHT_SYNC_STAGES 2

`endif
